/* Bender.yml */
package:
  name: rob

sources:
  - files:
      - common/rob_pkg.sv
      - rob/rob_occupancy_counter.sv
      - rob/rob_entry_array.sv
      - rob/rob_commit_select.sv
      - verilog/rob_flush_fsm.sv
      - verilog/rob_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/rob_tb.sv

/* all.f */
common/rob_pkg.sv
rob/rob_occupancy_counter.sv
rob/rob_entry_array.sv
rob/rob_commit_select.sv
verilog/rob_flush_fsm.sv
verilog/rob_top.sv
verification/tb_clock_gen.sv
verification/rob_tb.sv

/* common/rob_pkg.sv */
// ========================================
// rob package
// widths, writeback kind codes and the
// writeback info word shared by the ROB
// ========================================

package rob_pkg;

  // ========================================
  // widths
  // ========================================

  // pc and info word width
  localparam int PC_W = 32;

  // allocation, writeback and commit lanes
  localparam int LANES = 2;

  // writeback kind field width
  localparam int KIND_W = 2;

  // exception view field widths
  localparam int ECODE_W = 8;
  localparam int TVAL_W  = PC_W - ECODE_W;

  // ========================================
  // writeback kind codes
  // ========================================

  // plain completion
  localparam logic [KIND_W-1:0] WB_NORMAL    = 2'd0;
  // branch resolved to a new target
  localparam logic [KIND_W-1:0] WB_REDIRECT  = 2'd1;
  // faulting entry, never retired
  localparam logic [KIND_W-1:0] WB_EXCEPTION = 2'd2;

  // ========================================
  // writeback info word
  // ========================================

  // one word, read by kind
  // redirect uses the target view,
  // exception uses ecode and tval
  typedef union packed {
    logic [PC_W-1:0] target;
    struct packed {
      logic [ECODE_W-1:0] ecode;
      logic [TVAL_W-1:0]  tval;
    } exc;
  } rob_info_u;

endpackage

/* rob/rob_commit_select.sv */
// ========================================
// rob commit select
// in-order commit masks for the two head
// slots and flush request detection
// ========================================

`timescale 1ns/1ps

module rob_commit_select #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                                           running,
  input  logic [$clog2(ROB_DEPTH):0]                     count,
  input  logic                                           slot0_complete,
  input  logic                                           slot0_is_branch,
  input  logic [rob_pkg::KIND_W-1:0]                     slot0_kind,
  input  logic [rob_pkg::PC_W-1:0]                       slot0_pc,
  input  rob_pkg::rob_info_u                             slot0_info,
  input  logic                                           slot1_complete,
  input  logic                                           slot1_is_branch,
  input  logic [rob_pkg::KIND_W-1:0]                     slot1_kind,
  input  logic [rob_pkg::PC_W-1:0]                       slot1_pc,
  output logic [rob_pkg::LANES-1:0]                      commit_valid,
  output logic [rob_pkg::LANES-1:0][rob_pkg::PC_W-1:0]   commit_pc,
  output logic                                           flush_req,
  output logic [rob_pkg::KIND_W-1:0]                     flush_kind,
  output rob_pkg::rob_info_u                             flush_info
);

  import rob_pkg::*;

  localparam int CNT_W = $clog2(ROB_DEPTH) + 1;

  logic live0;
  logic live1;
  logic normal0;
  logic normal1;
  logic redirect0;
  logic except0;
  logic br_pair;

  // slot is live when it lies below the occupancy
  assign live0 = count > CNT_W'(0);
  assign live1 = count > CNT_W'(1);

  assign normal0   = slot0_kind == WB_NORMAL;
  assign normal1   = slot1_kind == WB_NORMAL;
  assign redirect0 = slot0_kind == WB_REDIRECT;
  assign except0   = slot0_kind == WB_EXCEPTION;

  // only one branch retires per cycle
  assign br_pair = slot0_is_branch && slot1_is_branch;

  // ========================================
  // commit masks
  // ========================================

  // exception at the head is never retired
  assign commit_valid[0] = running && live0 && slot0_complete && (normal0 || redirect0);

  // redirect at slot 0 commits alone
  assign commit_valid[1] = commit_valid[0] && normal0 && live1 && slot1_complete &&
                           normal1 && !br_pair;

  assign commit_pc[0] = slot0_pc;
  assign commit_pc[1] = slot1_pc;

  // ========================================
  // flush request
  // ========================================

  assign flush_req  = running && live0 && slot0_complete && (redirect0 || except0);
  assign flush_kind = slot0_kind;
  assign flush_info = slot0_info;

endmodule

/* rob/rob_entry_array.sv */
// ========================================
// rob entry array
// per-entry pc, branch flag, completion,
// kind and info, read at the head slots
// ========================================

`timescale 1ns/1ps

module rob_entry_array #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  logic                                               running,
  // allocation
  input  logic [rob_pkg::LANES-1:0]                          alloc_we,
  input  logic [$clog2(ROB_DEPTH)-1:0]                       tail,
  input  logic [rob_pkg::LANES-1:0][rob_pkg::PC_W-1:0]       alloc_pc,
  input  logic [rob_pkg::LANES-1:0]                          alloc_is_branch,
  // writeback
  input  logic [rob_pkg::LANES-1:0]                          wb_valid,
  input  logic [rob_pkg::LANES-1:0][$clog2(ROB_DEPTH)-1:0]   wb_idx,
  input  logic [rob_pkg::LANES-1:0][rob_pkg::KIND_W-1:0]     wb_kind,
  input  rob_pkg::rob_info_u [rob_pkg::LANES-1:0]            wb_info,
  // head read
  input  logic [$clog2(ROB_DEPTH)-1:0]                       head,
  output logic                                               slot0_complete,
  output logic                                               slot0_is_branch,
  output logic [rob_pkg::KIND_W-1:0]                         slot0_kind,
  output logic [rob_pkg::PC_W-1:0]                           slot0_pc,
  output rob_pkg::rob_info_u                                 slot0_info,
  output logic                                               slot1_complete,
  output logic                                               slot1_is_branch,
  output logic [rob_pkg::KIND_W-1:0]                         slot1_kind,
  output logic [rob_pkg::PC_W-1:0]                           slot1_pc,
  output rob_pkg::rob_info_u                                 slot1_info
);

  import rob_pkg::*;

  localparam int IDX_W = $clog2(ROB_DEPTH);

  // ========================================
  // storage
  // ========================================

  logic [PC_W-1:0]    pc_mem   [ROB_DEPTH];
  logic [KIND_W-1:0]  kind_mem [ROB_DEPTH];
  rob_info_u          info_mem [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] br_mem;
  logic [ROB_DEPTH-1:0] complete_q;

  logic [LANES-1:0][IDX_W-1:0] alloc_slot;
  logic [LANES-1:0]            wb_we;
  logic [IDX_W-1:0]            head_nxt;

  // lane i lands at tail + i, wrapping with the index width
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      alloc_slot[i] = tail + IDX_W'(i);
    end
  end

  // writebacks dropped outside RUN
  assign wb_we    = wb_valid & {LANES{running}};
  assign head_nxt = head + IDX_W'(1);

  // ========================================
  // write
  // ========================================

  // completion flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      complete_q <= '0;
    end else begin
      for (int i = 0; i < LANES; i++) begin
        if (alloc_we[i]) begin
          complete_q[alloc_slot[i]] <= 1'b0;
        end
      end
      for (int i = 0; i < LANES; i++) begin
        if (wb_we[i]) begin
          complete_q[wb_idx[i]] <= 1'b1;
        end
      end
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    for (int i = 0; i < LANES; i++) begin
      if (alloc_we[i]) begin
        pc_mem[alloc_slot[i]] <= alloc_pc[i];
        br_mem[alloc_slot[i]] <= alloc_is_branch[i];
      end
    end
    for (int i = 0; i < LANES; i++) begin
      if (wb_we[i]) begin
        kind_mem[wb_idx[i]] <= wb_kind[i];
        info_mem[wb_idx[i]] <= wb_info[i];
      end
    end
  end

  // ========================================
  // head slots
  // ========================================

  assign slot0_complete  = complete_q[head];
  assign slot0_is_branch = br_mem[head];
  assign slot0_kind      = kind_mem[head];
  assign slot0_pc        = pc_mem[head];
  assign slot0_info      = info_mem[head];

  assign slot1_complete  = complete_q[head_nxt];
  assign slot1_is_branch = br_mem[head_nxt];
  assign slot1_kind      = kind_mem[head_nxt];
  assign slot1_pc        = pc_mem[head_nxt];
  assign slot1_info      = info_mem[head_nxt];

endmodule

/* rob/rob_occupancy_counter.sv */
// ========================================
// rob occupancy counter
// head and tail pointers with wrap bit,
// occupancy and allocation acceptance
// ========================================

`timescale 1ns/1ps

module rob_occupancy_counter #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          running,
  input  logic                          clear,
  input  logic [rob_pkg::LANES-1:0]     alloc_valid,
  input  logic [rob_pkg::LANES-1:0]     commit_valid,
  output logic                          alloc_ready,
  output logic [rob_pkg::LANES-1:0]     alloc_we,
  output logic [$clog2(ROB_DEPTH)-1:0]  tail,
  output logic [$clog2(ROB_DEPTH)-1:0]  head,
  output logic [$clog2(ROB_DEPTH):0]    count
);

  import rob_pkg::*;

  localparam int IDX_W = $clog2(ROB_DEPTH);
  localparam int PTR_W = IDX_W + 1;

  // pointers carry one extra wrap bit
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [PTR_W-1:0] n_alloc;
  logic [PTR_W-1:0] n_commit;

  // occupancy straight from the pointer distance
  assign count = tail_q - head_q;

  // room for a full allocation group
  assign alloc_ready = running && (count <= PTR_W'(ROB_DEPTH - 2));
  assign alloc_we    = alloc_valid & {LANES{alloc_ready}};

  assign tail = tail_q[IDX_W-1:0];
  assign head = head_q[IDX_W-1:0];

  always_comb begin
    n_alloc  = '0;
    n_commit = '0;
    for (int i = 0; i < LANES; i++) begin
      n_alloc  = n_alloc + PTR_W'(alloc_we[i]);
      n_commit = n_commit + PTR_W'(commit_valid[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q <= '0;
      tail_q <= '0;
    end else if (clear) begin
      // flush empties the buffer
      head_q <= '0;
      tail_q <= '0;
    end else begin
      head_q <= head_q + n_commit;
      tail_q <= tail_q + n_alloc;
    end
  end

endmodule

/* verification/rob_cases.txt */
# columns: test op a b c d e, a to e in hex
# ALLOC a=lane valids b=branch flags c=pc0 d=pc1 e=random pc low bits
# WB a=port b=index c=kind d=info, IDLE a=cycles, END ends the run
1 IDLE 2 0 0 0 0
1 ALLOC 3 0 00001000 00001004 0
1 WB 0 0 0 0 0
1 WB 1 1 0 0 0
1 ALLOC 3 0 00001008 0000100c 0
2 ALLOC 3 0 00001100 00001104 6
2 ALLOC 3 3 00001200 00001204 6
2 ALLOC 1 0 00001300 00000000 6
2 ALLOC 3 0 00001400 00001404 0
2 IDLE 1 0 0 0 0
3 WB 0 3 0 0 0
3 WB 1 5 0 0 0
3 WB 0 2 0 0 0
3 WB 1 4 0 0 0
3 IDLE 2 0 0 0 0
4 WB 0 7 0 0 0
4 WB 1 6 0 0 0
4 IDLE 3 0 0 0 0
5 WB 0 0 1 00002000 0
5 IDLE 6 0 0 0 0
5 ALLOC 3 0 00003000 00003004 0
6 WB 1 1 2 25abcdef 0
6 WB 0 0 0 0 0
6 IDLE 6 0 0 0 0
6 ALLOC 1 0 00004000 00000000 0
6 END 0 0 0 0 0

/* verification/rob_tb.sv */
// ========================================
// rob testbench
// replays the case file against a model
// of the ROB and checks every cycle
// ========================================

`timescale 1ns/1ps

module rob_tb;

  import rob_pkg::*;

  localparam int              DEPTH    = 8;
  localparam int              RECOVER  = 2;
  localparam logic [PC_W-1:0] VEC_BASE = 32'h8000_0000;
  localparam int              IDX_W    = $clog2(DEPTH);

  localparam int MODE_RUN     = 0;
  localparam int MODE_FLUSH   = 1;
  localparam int MODE_RECOVER = 2;

  logic                          clk;
  logic                          rst_n;
  logic [LANES-1:0]              alloc_valid;
  logic [LANES-1:0][PC_W-1:0]    alloc_pc;
  logic [LANES-1:0]              alloc_is_branch;
  logic                          alloc_ready;
  logic [LANES-1:0][IDX_W-1:0]   alloc_idx;
  logic [LANES-1:0]              wb_valid;
  logic [LANES-1:0][IDX_W-1:0]   wb_idx;
  logic [LANES-1:0][KIND_W-1:0]  wb_kind;
  rob_info_u [LANES-1:0]         wb_info;
  logic [LANES-1:0]              commit_valid;
  logic [LANES-1:0][PC_W-1:0]    commit_pc;
  logic                          flush;
  logic [PC_W-1:0]               flush_pc;

  // staged inputs, applied on the next falling edge
  logic [LANES-1:0]              stg_valid;
  logic [LANES-1:0][PC_W-1:0]    stg_pc;
  logic [LANES-1:0]              stg_br;
  logic [LANES-1:0]              stg_wbv;
  logic [LANES-1:0][IDX_W-1:0]   stg_wbidx;
  logic [LANES-1:0][KIND_W-1:0]  stg_kind;
  logic [LANES-1:0][PC_W-1:0]    stg_info;

  // reference model
  int unsigned       m_head;
  int unsigned       m_tail;
  logic [PC_W-1:0]   m_pcs [$];
  logic              m_br [DEPTH];
  logic              m_done [DEPTH];
  logic [KIND_W-1:0] m_kind [DEPTH];
  logic [PC_W-1:0]   m_info [DEPTH];
  int                m_mode;
  int                m_rec_left;
  logic [PC_W-1:0]   m_redir;

  // cases and bookkeeping
  int                     case_test [$];
  string                  case_op [$];
  logic [4:0][PC_W-1:0]   case_arg [$];
  logic [31:0]            lfsr;
  int                     cur_test;
  int                     test_errs;
  int                     errors;
  int                     tests_pass;
  int                     tests_fail;
  int                     cycles;
  int                     cycle_limit;

  tb_clock_gen u_clk (.clk, .rst_n);

  rob_top #(
    .ROB_DEPTH(DEPTH), .RECOVER_CYCLES(RECOVER), .EXC_BASE(VEC_BASE)
  ) u_rob_top (
    .clk, .rst_n, .alloc_valid, .alloc_pc, .alloc_is_branch, .alloc_ready, .alloc_idx,
    .wb_valid, .wb_idx, .wb_kind, .wb_info, .commit_valid, .commit_pc, .flush, .flush_pc
  );

  // ========================================
  // helpers
  // ========================================

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [PC_W-1:0] mix_low_bits(input logic [PC_W-1:0] pc, input int nbits);
    logic [PC_W-1:0] r;
    logic [PC_W-1:0] mask;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[PC_W-2:0], lfsr[0]};
    end
    mask = (PC_W'(1) << nbits) - PC_W'(1);
    return (pc & ~mask) | (r & mask);
  endfunction

  task automatic check_hex(input string name, input logic [PC_W-1:0] exp,
                           input logic [PC_W-1:0] act);
    assert (act === exp) else begin
      $display("[FAIL] test %0d %s expected %h got %h", cur_test, name, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  task automatic clear_stage();
    stg_valid = '0;
    stg_pc    = '0;
    stg_br    = '0;
    stg_wbv   = '0;
    stg_wbidx = '0;
    stg_kind  = '0;
    stg_info  = '0;
  endtask

  task automatic load_cases();
    int fd;
    int n;
    int t;
    string line;
    string op;
    logic [PC_W-1:0] a;
    logic [PC_W-1:0] b;
    logic [PC_W-1:0] c;
    logic [PC_W-1:0] d;
    logic [PC_W-1:0] e;
    fd = $fopen("verification/rob_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file");
      errors++;
      return;
    end
    // comment and blank lines fail the scan and are skipped
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%d %s %h %h %h %h %h", t, op, a, b, c, d, e);
      if (n == 7) begin
        case_test.push_back(t);
        case_op.push_back(op);
        case_arg.push_back({e, d, c, b, a});
      end
    end
    $fclose(fd);
  endtask

  // ========================================
  // one clock cycle: check, drive, model
  // ========================================

  task automatic step_cycle();
    int unsigned cnt;
    int h0;
    int h1;
    int slot;
    logic running;
    logic ready;
    logic c0;
    logic c1;
    logic freq;
    @(negedge clk);
    cnt     = m_tail - m_head;
    h0      = m_head % DEPTH;
    h1      = (m_head + 1) % DEPTH;
    running = m_mode == MODE_RUN;
    ready   = running && (cnt <= DEPTH - 2);
    c0 = running && cnt > 0 && m_done[h0] &&
         (m_kind[h0] == WB_NORMAL || m_kind[h0] == WB_REDIRECT);
    c1 = c0 && m_kind[h0] == WB_NORMAL && cnt > 1 && m_done[h1] &&
         m_kind[h1] == WB_NORMAL && !(m_br[h0] && m_br[h1]);
    freq = running && cnt > 0 && m_done[h0] &&
           (m_kind[h0] == WB_REDIRECT || m_kind[h0] == WB_EXCEPTION);

    check_hex("alloc_ready", ready, alloc_ready);
    check_hex("alloc_idx[0]", m_tail % DEPTH, alloc_idx[0]);
    check_hex("alloc_idx[1]", (m_tail + 1) % DEPTH, alloc_idx[1]);
    check_hex("commit_valid", {c1, c0}, commit_valid);
    if (c0) check_hex("commit_pc[0]", m_pcs[0], commit_pc[0]);
    if (c1) check_hex("commit_pc[1]", m_pcs[1], commit_pc[1]);
    check_hex("flush", m_mode == MODE_FLUSH, flush);
    if (m_mode == MODE_FLUSH) check_hex("flush_pc", m_redir, flush_pc);

    alloc_valid     = stg_valid;
    alloc_pc        = stg_pc;
    alloc_is_branch = stg_br;
    wb_valid        = stg_wbv;
    wb_idx          = stg_wbidx;
    wb_kind         = stg_kind;
    wb_info         = stg_info;

    // retire from the front of the queue
    if (c0) void'(m_pcs.pop_front());
    if (c1) void'(m_pcs.pop_front());
    m_head = m_head + c0 + c1;
    if (ready) begin
      for (int i = 0; i < LANES; i++) begin
        if (stg_valid[i]) begin
          slot = (m_tail + i) % DEPTH;
          m_done[slot] = 1'b0;
          m_br[slot]   = stg_br[i];
          m_pcs.push_back(stg_pc[i]);
        end
      end
      m_tail = m_tail + stg_valid[0] + stg_valid[1];
    end
    for (int p = 0; p < LANES; p++) begin
      if (running && stg_wbv[p]) begin
        m_done[stg_wbidx[p]] = 1'b1;
        m_kind[stg_wbidx[p]] = stg_kind[p];
        m_info[stg_wbidx[p]] = stg_info[p];
      end
    end

    if (m_mode == MODE_RUN && freq) begin
      m_mode  = MODE_FLUSH;
      // exception vector spaced by one word per ecode
      m_redir = (m_kind[h0] == WB_REDIRECT) ? m_info[h0] :
                VEC_BASE + 4 * m_info[h0][PC_W-1 -: 8];
    end else if (m_mode == MODE_FLUSH) begin
      m_mode     = MODE_RECOVER;
      m_rec_left = RECOVER;
      m_head     = 0;
      m_tail     = 0;
      m_pcs.delete();
    end else if (m_mode == MODE_RECOVER) begin
      m_rec_left--;
      if (m_rec_left == 0) m_mode = MODE_RUN;
    end
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      tests_pass++;
      $display("test %0d passed", cur_test);
    end else begin
      tests_fail++;
      $display("test %0d failed with %0d mismatches", cur_test, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic run_cases();
    logic [4:0][PC_W-1:0] arg;
    string op;
    logic ended;
    ended = 1'b0;
    if (case_test.size() > 0) cur_test = case_test[0];
    for (int n = 0; n < case_test.size() && !ended; n++) begin
      if (case_test[n] != cur_test) begin
        finish_test();
        cur_test = case_test[n];
      end
      op  = case_op[n];
      arg = case_arg[n];
      clear_stage();
      if (op == "ALLOC") begin
        stg_valid = arg[0][1:0];
        stg_br    = arg[1][1:0];
        stg_pc[0] = mix_low_bits(arg[2], arg[4]);
        stg_pc[1] = mix_low_bits(arg[3], arg[4]);
        step_cycle();
      end else if (op == "WB") begin
        stg_wbv[arg[0][0]]   = 1'b1;
        stg_wbidx[arg[0][0]] = arg[1][IDX_W-1:0];
        stg_kind[arg[0][0]]  = arg[2][KIND_W-1:0];
        stg_info[arg[0][0]]  = arg[3];
        step_cycle();
      end else if (op == "IDLE") begin
        repeat (arg[0]) step_cycle();
      end else if (op == "END") begin
        ended = 1'b1;
      end else begin
        $display("test %0d has an unknown operation %s", cur_test, op);
        errors++;
        test_errs++;
      end
    end
    // one more cycle so the last operation is seen at the outputs
    clear_stage();
    step_cycle();
    finish_test();
  endtask

  // ========================================
  // main flow and timeout
  // ========================================

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("run stopped after %0d cycles without reaching the end", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    cycles      = 0;
    cycle_limit = 100;
    errors      = 0;
    test_errs   = 0;
    tests_pass  = 0;
    tests_fail  = 0;
    cur_test    = 0;
    lfsr        = 32'h69c4b519;
    clear_stage();
    alloc_valid     = '0;
    alloc_pc        = '0;
    alloc_is_branch = '0;
    wb_valid        = '0;
    wb_idx          = '0;
    wb_kind         = '0;
    wb_info         = '0;
    m_head     = 0;
    m_tail     = 0;
    m_mode     = MODE_RUN;
    m_rec_left = 0;
    m_redir    = '0;
    for (int i = 0; i < DEPTH; i++) begin
      m_br[i]   = 1'b0;
      m_done[i] = 1'b0;
      m_kind[i] = WB_NORMAL;
      m_info[i] = '0;
    end
    load_cases();
    cycle_limit = case_test.size() * 20 + 100;
    wait (rst_n === 1'b1);
    run_cases();
    $display("tests passed %0d failed %0d", tests_pass, tests_fail);
    if (errors == 0 && tests_fail == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verification/tb_clock_gen.sv */
// ========================================
// tb clock gen
// 100 ns clock and a two cycle reset
// ========================================

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // release on a falling edge, clear of the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* verilog/rob_flush_fsm.sv */
// ========================================
// rob flush state machine
// run, flush and recover with a recovery
// timer and redirect pc decode
// ========================================

`timescale 1ns/1ps

module rob_flush_fsm #(
  parameter int                         RECOVER_CYCLES = 2,
  parameter logic [rob_pkg::PC_W-1:0]   EXC_BASE       = 32'h8000_0000
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_req,
  input  logic [rob_pkg::KIND_W-1:0]    flush_kind,
  input  rob_pkg::rob_info_u            flush_info,
  output logic                          running,
  output logic                          flush,
  output logic [rob_pkg::PC_W-1:0]      flush_pc
);

  import rob_pkg::*;

  localparam int TMR_W = $clog2(RECOVER_CYCLES + 1);

  localparam logic [1:0] ST_RUN     = 2'd0;
  localparam logic [1:0] ST_FLUSH   = 2'd1;
  localparam logic [1:0] ST_RECOVER = 2'd2;

  logic [1:0]        state_q;
  logic [TMR_W-1:0]  timer_q;
  logic [KIND_W-1:0] kind_q;
  rob_info_u         info_q;

  // ========================================
  // state and recovery timer
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_RUN;
      timer_q <= '0;
    end else begin
      case (state_q)
        ST_RUN: begin
          if (flush_req) begin
            state_q <= ST_FLUSH;
          end
        end
        ST_FLUSH: begin
          // one strobe cycle, then hold off allocation
          state_q <= ST_RECOVER;
          timer_q <= TMR_W'(RECOVER_CYCLES - 1);
        end
        ST_RECOVER: begin
          if (timer_q == '0) begin
            state_q <= ST_RUN;
          end else begin
            timer_q <= timer_q - TMR_W'(1);
          end
        end
        default: begin
          state_q <= ST_RUN;
        end
      endcase
    end
  end

  // head entry captured at the request
  always_ff @(posedge clk) begin
    if (state_q == ST_RUN && flush_req) begin
      kind_q <= flush_kind;
      info_q <= flush_info;
    end
  end

  // ========================================
  // outputs
  // ========================================

  assign running = state_q == ST_RUN;
  assign flush   = state_q == ST_FLUSH;

  // redirect takes the target, exception goes to the vector
  assign flush_pc = (kind_q == WB_REDIRECT) ? info_q.target :
                    EXC_BASE + PC_W'({info_q.exc.ecode, 2'b00});

endmodule

/* verilog/rob_top.sv */
// ========================================
// rob top
// reorder buffer with dual allocation,
// writeback, commit and flush recovery
// ========================================

`timescale 1ns/1ps

module rob_top #(
  parameter int                         ROB_DEPTH      = 8,
  parameter int                         RECOVER_CYCLES = 2,
  parameter logic [rob_pkg::PC_W-1:0]   EXC_BASE       = 32'h8000_0000
) (
  input  logic                                               clk,
  input  logic                                               rst_n,
  // allocation
  input  logic [rob_pkg::LANES-1:0]                          alloc_valid,
  input  logic [rob_pkg::LANES-1:0][rob_pkg::PC_W-1:0]       alloc_pc,
  input  logic [rob_pkg::LANES-1:0]                          alloc_is_branch,
  output logic                                               alloc_ready,
  output logic [rob_pkg::LANES-1:0][$clog2(ROB_DEPTH)-1:0]   alloc_idx,
  // writeback
  input  logic [rob_pkg::LANES-1:0]                          wb_valid,
  input  logic [rob_pkg::LANES-1:0][$clog2(ROB_DEPTH)-1:0]   wb_idx,
  input  logic [rob_pkg::LANES-1:0][rob_pkg::KIND_W-1:0]     wb_kind,
  input  rob_pkg::rob_info_u [rob_pkg::LANES-1:0]            wb_info,
  // commit
  output logic [rob_pkg::LANES-1:0]                          commit_valid,
  output logic [rob_pkg::LANES-1:0][rob_pkg::PC_W-1:0]       commit_pc,
  // flush
  output logic                                               flush,
  output logic [rob_pkg::PC_W-1:0]                           flush_pc
);

  import rob_pkg::*;

  localparam int IDX_W = $clog2(ROB_DEPTH);

  logic                 running;
  logic [LANES-1:0]     alloc_we;
  logic [IDX_W-1:0]     tail;
  logic [IDX_W-1:0]     head;
  logic [IDX_W:0]       count;
  logic                 flush_req;
  logic [KIND_W-1:0]    flush_kind;
  rob_info_u            flush_info;

  logic                 s0_complete;
  logic                 s1_complete;
  logic                 s0_is_branch;
  logic                 s1_is_branch;
  logic [KIND_W-1:0]    s0_kind;
  logic [KIND_W-1:0]    s1_kind;
  logic [PC_W-1:0]      s0_pc;
  logic [PC_W-1:0]      s1_pc;
  rob_info_u            s0_info;

  // index handed back to dispatch per lane
  for (genvar i = 0; i < LANES; i++) begin : g_alloc_idx
    assign alloc_idx[i] = tail + IDX_W'(i);
  end

  rob_occupancy_counter #(.ROB_DEPTH(ROB_DEPTH)) u_counter (
    .clk, .rst_n, .running, .clear(flush), .alloc_valid, .commit_valid,
    .alloc_ready, .alloc_we, .tail, .head, .count
  );

  rob_entry_array #(.ROB_DEPTH(ROB_DEPTH)) u_array (
    .clk, .rst_n, .running, .alloc_we, .tail, .alloc_pc, .alloc_is_branch,
    .wb_valid, .wb_idx, .wb_kind, .wb_info, .head,
    .slot0_complete(s0_complete), .slot0_is_branch(s0_is_branch),
    .slot0_kind(s0_kind), .slot0_pc(s0_pc), .slot0_info(s0_info),
    .slot1_complete(s1_complete), .slot1_is_branch(s1_is_branch),
    .slot1_kind(s1_kind), .slot1_pc(s1_pc), .slot1_info()
  );

  rob_commit_select #(.ROB_DEPTH(ROB_DEPTH)) u_commit (
    .running, .count,
    .slot0_complete(s0_complete), .slot0_is_branch(s0_is_branch),
    .slot0_kind(s0_kind), .slot0_pc(s0_pc), .slot0_info(s0_info),
    .slot1_complete(s1_complete), .slot1_is_branch(s1_is_branch),
    .slot1_kind(s1_kind), .slot1_pc(s1_pc),
    .commit_valid, .commit_pc, .flush_req, .flush_kind, .flush_info
  );

  rob_flush_fsm #(.RECOVER_CYCLES(RECOVER_CYCLES), .EXC_BASE(EXC_BASE)) u_flush (
    .clk, .rst_n, .flush_req, .flush_kind, .flush_info, .running, .flush, .flush_pc
  );

endmodule
